/* sources.f */
common/dmac_cfg_pkg.sv
common/dmac_bus_pkg.sv
design/grant_align_stage.sv
design/status_steer.sv
design/rdata_steer.sv
design/xfer_gate.sv
design/dmac_mi_to_ch_mux.sv
testbench/tb_dmac_mi_to_ch_mux.sv

/* testbench/tb_dmac_mi_to_ch_mux.sv */
/*
  Testbench for the master interface to channel mux
  directed tests for reset, status and read data steering, grant
  alignment, strobe gating and the lock mask, with a small model of
  the alignment registers checked on every clock
*/
`timescale 1ns/100ps
`default_nettype none

module tb_dmac_mi_to_ch_mux
  import dmac_cfg_pkg::*;
  import dmac_bus_pkg::*;
();

  localparam int NUM_CH      = NUM_CH_DEF;
  localparam int NUM_MASTERS = NUM_MASTERS_DEF;
  localparam int GW          = 2 * NUM_CH;
  // tests take about 200 cycles, limit leaves ample margin
  localparam int TIMEOUT_CYCLES = 2000;

  logic                          hclk;
  logic                          hresetn;
  mi_status_t                    mi_status [NUM_MASTERS];
  mi_xfer_t                      xfer      [NUM_MASTERS];
  hrdata_t                       hrdata    [NUM_MASTERS];
  logic [NUM_MASTERS-1:0][GW-1:0] grant;
  master_sel_e                   ch_sms     [NUM_CH];
  master_sel_e                   ch_dms_lms [NUM_CH];
  logic [NUM_CH-1:0]             src_tfr_on_dst_sm;
  ch_status_t                    ch_status_src [NUM_CH];
  ch_status_t                    ch_status_dst [NUM_CH];
  hrdata_t                       hrdata_ch_ss  [NUM_CH];
  hrdata_t                       hrdata_ll_ds  [NUM_CH];
  logic [NUM_CH-1:0]             pop_ch;
  logic [NUM_CH-1:0]             pop_data_vld_ch;
  logic [NUM_CH-1:0]             push_ch;
  logic [NUM_CH-1:0]             mask_ch_disable_hlock_ch;
  logic [NUM_MASTERS-1:0][GW-1:0] grant_align;
  logic [NUM_MASTERS-1:0][GW-1:0] dp_grt_align;

  // expected alignment registers
  logic [NUM_MASTERS-1:0][GW-1:0] exp_ga;
  logic [NUM_MASTERS-1:0][GW-1:0] exp_dga;
  integer seed;
  int     cycle_cnt = 0;

  dmac_mi_to_ch_mux u_dmac_mi_to_ch_mux (
    .hclk                     (hclk),
    .hresetn                  (hresetn),
    .mi_status                (mi_status),
    .xfer                     (xfer),
    .hrdata                   (hrdata),
    .grant                    (grant),
    .ch_sms                   (ch_sms),
    .ch_dms_lms               (ch_dms_lms),
    .src_tfr_on_dst_sm        (src_tfr_on_dst_sm),
    .ch_status_src            (ch_status_src),
    .ch_status_dst            (ch_status_dst),
    .hrdata_ch_ss             (hrdata_ch_ss),
    .hrdata_ll_ds             (hrdata_ll_ds),
    .pop_ch                   (pop_ch),
    .pop_data_vld_ch          (pop_data_vld_ch),
    .push_ch                  (push_ch),
    .mask_ch_disable_hlock_ch (mask_ch_disable_hlock_ch),
    .grant_align              (grant_align),
    .dp_grt_align             (dp_grt_align)
  );

  // 100 ns clock
  always #50 hclk = ~hclk;

  // run limit
  always @(posedge hclk)
  begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES)
    begin
      $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("*** FAILED ***");
      $fatal(1, "run stopped by timeout");
    end
  end

  // ------------------------------
  // reference model
  // ------------------------------

  task automatic report_mismatch(input string what);
    $display("MISMATCH at %0t ns: %s", $time, what);
    $display("*** FAILED ***");
    $fatal(1, "check failed");
  endtask

  // selected master status, zero for an unfitted master
  function automatic ch_status_t exp_status(input master_sel_e code);
    ch_status_t c;
    c = '0;
    if (int'(code) < NUM_MASTERS)
    begin
      c.hgrant      = mi_status[int'(code)].hgrant;
      c.hresp       = mi_status[int'(code)].hresp;
      c.hready      = mi_status[int'(code)].hready;
      c.dp_complete = mi_status[int'(code)].dp_complete;
    end
    return c;
  endfunction

  function automatic hrdata_t exp_rdata(input master_sel_e code);
    return (int'(code) < NUM_MASTERS) ? hrdata[int'(code)] : hrdata_t'(0);
  endfunction

  // one clock, model the alignment rule and compare both registers
  task automatic advance();
    logic [NUM_MASTERS-1:0][GW-1:0] next_ga;
    logic [NUM_MASTERS-1:0][GW-1:0] next_dga;
    for (int m = 0; m < NUM_MASTERS; m++)
    begin
      next_ga[m]  = (xfer[m].tfr_req_pre && mi_status[m].hready) ? grant[m] : exp_ga[m];
      next_dga[m] = mi_status[m].hready ? exp_ga[m] : exp_dga[m];
    end
    @(negedge hclk);
    exp_ga  = next_ga;
    exp_dga = next_dga;
    assert (grant_align === exp_ga && dp_grt_align === exp_dga)
    else report_mismatch($sformatf("aligned grants %h/%h, expected %h/%h",
                                   grant_align, dp_grt_align, exp_ga, exp_dga));
  endtask

  task automatic check_gates_quiet(input string when);
    assert (grant_align === '0 && dp_grt_align === '0)
    else report_mismatch({"aligned grants not zero ", when});
    assert (pop_ch === '0 && pop_data_vld_ch === '0 && push_ch === '0
            && mask_ch_disable_hlock_ch === '0)
    else report_mismatch({"gated strobes active ", when});
  endtask

  // aligned grant on one bit of master m, zero for the others
  task automatic load_grant(input int m, input int bit_idx);
    for (int k = 0; k < NUM_MASTERS; k++)
    begin
      grant[k] = '0;
      xfer[k]  = '0;
      xfer[k].tfr_req_pre = 1'b1;
      mi_status[k].hready = 1'b1;
    end
    grant[m][bit_idx] = 1'b1;
    advance();
    for (int k = 0; k < NUM_MASTERS; k++)
      xfer[k].tfr_req_pre = 1'b0;
    // second edge carries it into the data phase copy
    advance();
  endtask

  // ------------------------------
  // directed tests
  // ------------------------------

  task automatic test_reset();
    for (int m = 0; m < NUM_MASTERS; m++)
    begin
      xfer[m]      = '1;
      mi_status[m] = '1;
      grant[m]     = '1;
    end
    repeat (8)
    begin
      @(negedge hclk);
      check_gates_quiet("during reset");
    end
    // release with the request low so the registers stay empty
    for (int m = 0; m < NUM_MASTERS; m++)
      xfer[m].tfr_req_pre = 1'b0;
    hresetn = 1'b1;
    #10;
    check_gates_quiet("after reset");
    advance();
    check_gates_quiet("one cycle after reset");
    for (int m = 0; m < NUM_MASTERS; m++)
      xfer[m] = '0;
    advance();
  endtask

  task automatic test_steering(input bit data_side);
    repeat (30)
    begin
      for (int m = 0; m < NUM_MASTERS; m++)
      begin
        mi_status[m] = 5'($random(seed));
        hrdata[m]    = $random(seed);
      end
      // codes include MS_M3 and MS_M4, beyond the fitted masters
      for (int i = 0; i < NUM_CH; i++)
      begin
        ch_sms[i]     = master_sel_e'($random(seed) & 3);
        ch_dms_lms[i] = master_sel_e'($random(seed) & 3);
      end
      #10;
      for (int i = 0; i < NUM_CH; i++)
      begin
        if (data_side)
        begin
          assert (hrdata_ch_ss[i] === exp_rdata(ch_sms[i])
                  && hrdata_ll_ds[i] === exp_rdata(ch_dms_lms[i]))
          else report_mismatch($sformatf("read data on channel %0d", i));
        end
        else
        begin
          assert (ch_status_src[i] === exp_status(ch_sms[i])
                  && ch_status_dst[i] === exp_status(ch_dms_lms[i]))
          else report_mismatch($sformatf("status on channel %0d", i));
        end
      end
      advance();
    end
  endtask

  task automatic test_grant_align();
    logic [GW-1:0] a;
    a = GW'($random(seed)) | GW'(1);
    for (int m = 0; m < NUM_MASTERS; m++)
    begin
      mi_status[m].hready = 1'b1;
      grant[m] = GW'($random(seed));
    end
    grant[0] = a;
    xfer[0].tfr_req_pre = 1'b1;
    advance();
    assert (grant_align[0] === a) else report_mismatch("address phase grant not loaded");
    // wait state, new grant and request must not load
    mi_status[0].hready = 1'b0;
    grant[0] = ~a;
    advance();
    assert (grant_align[0] === a && dp_grt_align[0] === '0)
    else report_mismatch("alignment registers moved with hready low");
    mi_status[0].hready = 1'b1;
    xfer[0].tfr_req_pre = 1'b0;
    advance();
    assert (dp_grt_align[0] === a) else report_mismatch("data phase grant not loaded");
  endtask

  task automatic test_push_pop(input int ch, input int m, input bit on_dst);
    logic [NUM_CH-1:0] one_hot;
    logic [NUM_CH-1:0] exp_pop;
    one_hot = '0;
    one_hot[ch] = 1'b1;
    for (int i = 0; i < NUM_CH; i++)
    begin
      ch_sms[i]     = MS_M4;
      ch_dms_lms[i] = MS_M4;
    end
    ch_sms[ch]        = master_sel_e'(m);
    ch_dms_lms[ch]    = master_sel_e'(m);
    src_tfr_on_dst_sm = '0;
    load_grant(m, 2 * ch + int'(on_dst));
    src_tfr_on_dst_sm[ch] = on_dst;
    for (int k = 0; k < NUM_MASTERS; k++)
    begin
      xfer[k].push         = 1'b1;
      xfer[k].pop          = 1'b1;
      xfer[k].pop_data_vld = 1'b1;
    end
    #10;
    // pops only follow the destination bit
    exp_pop = on_dst ? one_hot : '0;
    assert (push_ch === one_hot && pop_ch === exp_pop && pop_data_vld_ch === exp_pop
            && mask_ch_disable_hlock_ch === '0)
    else report_mismatch($sformatf("ch %0d master %0d dst %0b: push %b pop %b vld %b",
                                   ch, m, on_dst, push_ch, pop_ch, pop_data_vld_ch));
    advance();
    // selects name the other master, which holds no grant
    ch_sms[ch]     = master_sel_e'((m + 1) % NUM_MASTERS);
    ch_dms_lms[ch] = master_sel_e'((m + 1) % NUM_MASTERS);
    #10;
    assert (push_ch === '0 && pop_ch === '0 && pop_data_vld_ch === '0)
    else report_mismatch($sformatf("strobes passed to ch %0d from unselected master", ch));
    advance();
    ch_sms[ch]     = master_sel_e'(m);
    ch_dms_lms[ch] = master_sel_e'(m);
    // push now looks at the other bit, which holds no grant
    src_tfr_on_dst_sm[ch] = !on_dst;
    #10;
    assert (push_ch === '0)
    else report_mismatch($sformatf("push %b on the ungranted bit of ch %0d", push_ch, ch));
    advance();
  endtask

  task automatic test_lock_mask(input int ch, input int m, input bit on_dst);
    load_grant(m, 2 * ch + int'(on_dst));
    // only the granted master raises its mask strobe
    xfer[m].mask_ch_disable_hlock = 1'b1;
    #10;
    assert (mask_ch_disable_hlock_ch === NUM_CH'(1) << ch)
    else report_mismatch($sformatf("lock mask %b for ch %0d master %0d",
                                   mask_ch_disable_hlock_ch, ch, m));
    advance();
  endtask

  // ------------------------------
  // main sequence
  // ------------------------------

  initial
  begin
    seed    = 32'h33027cb8;
    hclk    = 1'b0;
    hresetn = 1'b0;
    grant   = '0;
    src_tfr_on_dst_sm = '0;
    exp_ga  = '0;
    exp_dga = '0;
    for (int m = 0; m < NUM_MASTERS; m++)
    begin
      mi_status[m] = '0;
      xfer[m]      = '0;
      hrdata[m]    = '0;
    end
    for (int i = 0; i < NUM_CH; i++)
    begin
      ch_sms[i]     = MS_M1;
      ch_dms_lms[i] = MS_M1;
    end
    test_reset();
    test_steering(1'b0);
    test_steering(1'b1);
    test_grant_align();
    for (int ch = 0; ch < NUM_CH; ch++)
      for (int m = 0; m < NUM_MASTERS; m++)
      begin
        test_push_pop(ch, m, 1'b0);
        test_push_pop(ch, m, 1'b1);
        test_lock_mask(ch, m, 1'b0);
        test_lock_mask(ch, m, 1'b1);
      end
    $display("*** PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire

/* design/dmac_mi_to_ch_mux.sv */
/*
  Master interface to channel mux
  top of the steering path between the AHB master interfaces and the
  channel state machines: grant alignment, status and read data
  steering, and transfer strobe gating
*/
`timescale 1ns/100ps
`default_nettype none

module dmac_mi_to_ch_mux
  import dmac_cfg_pkg::*;
  import dmac_bus_pkg::*;
#(
  parameter int NUM_CH      = NUM_CH_DEF,
  parameter int NUM_MASTERS = NUM_MASTERS_DEF
) (
  input  logic                                 hclk,
  input  logic                                 hresetn,
  // master interface side
  input  mi_status_t                           mi_status [NUM_MASTERS],
  input  mi_xfer_t                             xfer      [NUM_MASTERS],
  input  hrdata_t                              hrdata    [NUM_MASTERS],
  input  logic [NUM_MASTERS-1:0][2*NUM_CH-1:0] grant,
  // channel configuration
  input  master_sel_e                          ch_sms     [NUM_CH],
  input  master_sel_e                          ch_dms_lms [NUM_CH],
  input  logic [NUM_CH-1:0]                    src_tfr_on_dst_sm,
  // channel side
  output ch_status_t                           ch_status_src [NUM_CH],
  output ch_status_t                           ch_status_dst [NUM_CH],
  output hrdata_t                              hrdata_ch_ss  [NUM_CH],
  output hrdata_t                              hrdata_ll_ds  [NUM_CH],
  output logic [NUM_CH-1:0]                    pop_ch,
  output logic [NUM_CH-1:0]                    pop_data_vld_ch,
  output logic [NUM_CH-1:0]                    push_ch,
  output logic [NUM_CH-1:0]                    mask_ch_disable_hlock_ch,
  // aligned grants, also used by the channel to master mux
  output logic [NUM_MASTERS-1:0][2*NUM_CH-1:0] grant_align,
  output logic [NUM_MASTERS-1:0][2*NUM_CH-1:0] dp_grt_align
);

  // ------------------------------
  // grant alignment
  // ------------------------------

  grant_align_stage #(.NUM_CH(NUM_CH), .NUM_MASTERS(NUM_MASTERS)) u_grant_align_stage (
    .hclk         (hclk),
    .hresetn      (hresetn),
    .grant        (grant),
    .xfer         (xfer),
    .mi_status    (mi_status),
    .grant_align  (grant_align),
    .dp_grt_align (dp_grt_align)
  );

  // ------------------------------
  // steering
  // ------------------------------

  status_steer #(.NUM_CH(NUM_CH), .NUM_MASTERS(NUM_MASTERS)) u_status_steer (
    .mi_status     (mi_status),
    .ch_sms        (ch_sms),
    .ch_dms_lms    (ch_dms_lms),
    .ch_status_src (ch_status_src),
    .ch_status_dst (ch_status_dst)
  );

  rdata_steer #(.NUM_CH(NUM_CH), .NUM_MASTERS(NUM_MASTERS)) u_rdata_steer (
    .hrdata       (hrdata),
    .ch_sms       (ch_sms),
    .ch_dms_lms   (ch_dms_lms),
    .hrdata_ch_ss (hrdata_ch_ss),
    .hrdata_ll_ds (hrdata_ll_ds)
  );

  // ------------------------------
  // strobe gating
  // ------------------------------

  // gated by the registered grants, so nothing fires out of reset
  xfer_gate #(.NUM_CH(NUM_CH), .NUM_MASTERS(NUM_MASTERS)) u_xfer_gate (
    .xfer                     (xfer),
    .grant_align              (grant_align),
    .dp_grt_align             (dp_grt_align),
    .ch_sms                   (ch_sms),
    .ch_dms_lms               (ch_dms_lms),
    .src_tfr_on_dst_sm        (src_tfr_on_dst_sm),
    .pop_ch                   (pop_ch),
    .pop_data_vld_ch          (pop_data_vld_ch),
    .push_ch                  (push_ch),
    .mask_ch_disable_hlock_ch (mask_ch_disable_hlock_ch)
  );

endmodule

`default_nettype wire

/* design/xfer_gate.sv */
/*
  Transfer strobe gating
  passes push, pop, pop data valid and the lock mask strobe of each
  master to a channel only while the aligned grant names that channel
*/
`timescale 1ns/100ps
`default_nettype none

module xfer_gate
  import dmac_cfg_pkg::*;
  import dmac_bus_pkg::*;
#(
  parameter int NUM_CH      = NUM_CH_DEF,
  parameter int NUM_MASTERS = NUM_MASTERS_DEF
) (
  input  mi_xfer_t                             xfer [NUM_MASTERS],
  input  logic [NUM_MASTERS-1:0][2*NUM_CH-1:0] grant_align,
  input  logic [NUM_MASTERS-1:0][2*NUM_CH-1:0] dp_grt_align,
  input  master_sel_e                          ch_sms     [NUM_CH],
  input  master_sel_e                          ch_dms_lms [NUM_CH],
  // dst fsm doing a read, lli fetch
  input  logic [NUM_CH-1:0]                    src_tfr_on_dst_sm,
  output logic [NUM_CH-1:0]                    pop_ch,
  output logic [NUM_CH-1:0]                    pop_data_vld_ch,
  output logic [NUM_CH-1:0]                    push_ch,
  output logic [NUM_CH-1:0]                    mask_ch_disable_hlock_ch
);

  // ------------------------------
  // gating
  // ------------------------------

  always_comb
  begin : gate_proc
    logic src_hit;
    logic dst_hit;
    int   src_bit;
    int   dst_bit;
    int   push_bit;
    for (int i = 0; i < NUM_CH; i++)
    begin
      pop_ch[i]                   = 1'b0;
      pop_data_vld_ch[i]          = 1'b0;
      push_ch[i]                  = 1'b0;
      mask_ch_disable_hlock_ch[i] = 1'b0;
      // even bit src fsm, odd bit dst fsm
      src_bit = 2 * i;
      dst_bit = 2 * i + 1;
      // pushing lli words happens while the dst fsm holds the grant
      push_bit = src_tfr_on_dst_sm[i] ? dst_bit : src_bit;
      for (int j = 0; j < NUM_MASTERS; j++)
      begin
        src_hit = (int'(ch_sms[i]) == j);
        dst_hit = (int'(ch_dms_lms[i]) == j);
        // pop on the address phase, writes only come from the dst fsm
        pop_ch[i] = pop_ch[i]
                  | (xfer[j].pop & dst_hit & grant_align[j][dst_bit]);
        // write data phase done
        pop_data_vld_ch[i] = pop_data_vld_ch[i]
                           | (xfer[j].pop_data_vld & dst_hit & dp_grt_align[j][dst_bit]);
        // read data arrives in the data phase
        push_ch[i] = push_ch[i]
                   | (xfer[j].push & src_hit & dp_grt_align[j][push_bit]);
        // an idle master cannot pulse the mask, so a stale grant is harmless
        mask_ch_disable_hlock_ch[i] = mask_ch_disable_hlock_ch[i]
                                    | (xfer[j].mask_ch_disable_hlock
                                       & (grant_align[j][src_bit] | grant_align[j][dst_bit]));
      end
    end
  end

endmodule

`default_nettype wire

/* design/rdata_steer.sv */
/*
  Read data steering
  drives each channel's source data/status read bus and its
  linked-list/destination status read bus from the selected master
*/
`timescale 1ns/100ps
`default_nettype none

module rdata_steer
  import dmac_cfg_pkg::*;
  import dmac_bus_pkg::*;
#(
  parameter int NUM_CH      = NUM_CH_DEF,
  parameter int NUM_MASTERS = NUM_MASTERS_DEF
) (
  input  hrdata_t     hrdata       [NUM_MASTERS],
  input  master_sel_e ch_sms       [NUM_CH],
  input  master_sel_e ch_dms_lms   [NUM_CH],
  // dma read data and sstat, to channel fifo and sstat register
  output hrdata_t     hrdata_ch_ss [NUM_CH],
  // lli words for sar/dar/llp/ctl and dstat
  output hrdata_t     hrdata_ll_ds [NUM_CH]
);

  // ------------------------------
  // steering
  // ------------------------------

  // the two buses may sit on different AHB layers
  // so each channel picks its masters independently
  always_comb
  begin
    for (int i = 0; i < NUM_CH; i++)
    begin
      // unfitted master codes read back zero
      hrdata_ch_ss[i] = '0;
      hrdata_ll_ds[i] = '0;
      for (int j = 0; j < NUM_MASTERS; j++)
      begin
        if (int'(ch_sms[i]) == j)
          hrdata_ch_ss[i] = hrdata[j];
        if (int'(ch_dms_lms[i]) == j)
          hrdata_ll_ds[i] = hrdata[j];
      end
    end
  end

endmodule

`default_nettype wire

/* design/status_steer.sv */
/*
  Status steering
  routes each master interface's grant, response, ready and data phase
  complete to the source and destination state machines of every
  channel, following the channel master selects
*/
`timescale 1ns/100ps
`default_nettype none

module status_steer
  import dmac_cfg_pkg::*;
  import dmac_bus_pkg::*;
#(
  parameter int NUM_CH      = NUM_CH_DEF,
  parameter int NUM_MASTERS = NUM_MASTERS_DEF
) (
  input  mi_status_t  mi_status     [NUM_MASTERS],
  // ch_sms straight from ctlx.sms
  input  master_sel_e ch_sms        [NUM_CH],
  // ch_dms_lms switches between ctlx.dms and llpx.lms in the dst fsm
  input  master_sel_e ch_dms_lms    [NUM_CH],
  output ch_status_t  ch_status_src [NUM_CH],
  output ch_status_t  ch_status_dst [NUM_CH]
);

  // ------------------------------
  // field mapping
  // ------------------------------

  // master side bundle to channel side bundle
  function automatic ch_status_t to_ch_status(input mi_status_t s);
    ch_status_t c;
    c.hgrant      = s.hgrant;
    c.hresp       = s.hresp;
    c.hready      = s.hready;
    c.dp_complete = s.dp_complete;
    return c;
  endfunction

  // ------------------------------
  // steering
  // ------------------------------

  // both buses default to zero
  // a select beyond the fitted masters never matches, so stays zero
  always_comb
  begin
    for (int i = 0; i < NUM_CH; i++)
    begin
      ch_status_src[i] = '0;
      ch_status_dst[i] = '0;
      for (int j = 0; j < NUM_MASTERS; j++)
      begin
        // src fsm follows its source master
        if (int'(ch_sms[i]) == j)
          ch_status_src[i] = to_ch_status(mi_status[j]);
        // dst fsm, also used for lli fetch and status write back
        if (int'(ch_dms_lms[i]) == j)
          ch_status_dst[i] = to_ch_status(mi_status[j]);
      end
    end
  end

endmodule

`default_nettype wire

/* design/grant_align_stage.sv */
/*
  Grant alignment stage
  registers each master interface's arbiter grant twice: once aligned
  to the address phase and once to the data phase of the current
  transfer, both frozen while that master's hready is low
*/
`timescale 1ns/100ps
`default_nettype none

module grant_align_stage
  import dmac_cfg_pkg::*;
  import dmac_bus_pkg::*;
#(
  parameter int NUM_CH      = NUM_CH_DEF,
  parameter int NUM_MASTERS = NUM_MASTERS_DEF
) (
  input  logic                                    hclk,
  input  logic                                    hresetn,
  // arbiter grants, one bit per src/dst state machine
  input  logic [NUM_MASTERS-1:0][2*NUM_CH-1:0]    grant,
  input  mi_xfer_t                                xfer [NUM_MASTERS],
  input  mi_status_t                              mi_status [NUM_MASTERS],
  output logic [NUM_MASTERS-1:0][2*NUM_CH-1:0]    grant_align,
  output logic [NUM_MASTERS-1:0][2*NUM_CH-1:0]    dp_grt_align
);

  // state machines per master, src and dst of every channel
  localparam int NUM_PER = 2 * NUM_CH;

  // request gated with hready, one per master
  logic [NUM_MASTERS-1:0] tfr_req;

  // ------------------------------
  // gated transfer request
  // ------------------------------

  // gating done here to keep it off the transfer control path
  always_comb
  begin
    for (int m = 0; m < NUM_MASTERS; m++)
      tfr_req[m] = xfer[m].tfr_req_pre & mi_status[m].hready;
  end

  // ------------------------------
  // alignment registers
  // ------------------------------

  // arbiter output moves on the first address phase of the transfer
  // address phase copy loads on the gated request
  // data phase copy trails it by one completed beat
  always_ff @(posedge hclk or negedge hresetn)
  begin
    if (!hresetn)
    begin
      grant_align  <= '0;
      dp_grt_align <= '0;
    end
    else
    begin
      for (int m = 0; m < NUM_MASTERS; m++)
      begin
        if (tfr_req[m])
          grant_align[m] <= grant[m][NUM_PER-1:0];
        // wait states hold the data phase owner
        if (mi_status[m].hready)
          dp_grt_align[m] <= grant_align[m];
      end
    end
  end

endmodule

`default_nettype wire

/* common/dmac_bus_pkg.sv */
/*
  DMA controller bus types
  packed bundles for master interface status, the status seen by one
  channel state machine, per-master transfer strobes and read data
*/
`default_nettype none

package dmac_bus_pkg;

  import dmac_cfg_pkg::*;

  // AHB response, OKAY/ERROR/RETRY/SPLIT
  typedef logic [1:0] hresp_t;

  // ------------------------------
  // master interface side
  // ------------------------------

  // status returned by one master interface (mbiu)
  typedef struct packed {
    logic   hgrant;       // bus granted, always high on AHB-Lite
    hresp_t hresp;
    logic   hready;
    logic   dp_complete;  // last data phase of the request done
  } mi_status_t;

  // strobes from central transfer control, one set per master
  typedef struct packed {
    logic tfr_req_pre;            // request before hready gating
    logic push;                   // read data phase complete
    logic pop;                    // address phase of a write
    logic pop_data_vld;           // write data phase complete
    logic mask_ch_disable_hlock;
  } mi_xfer_t;

  // ------------------------------
  // channel side
  // ------------------------------

  // same fields, as delivered to a src or dst state machine
  typedef struct packed {
    logic   hgrant;
    hresp_t hresp;
    logic   hready;
    logic   dp_complete;
  } ch_status_t;

  // one read data word
  typedef logic [DATA_W-1:0] hrdata_t;

endpackage

`default_nettype wire

/* common/dmac_cfg_pkg.sv */
/*
  DMA controller configuration
  default channel and master interface counts, the read data width
  and the per-channel master select code
*/
`default_nettype none

package dmac_cfg_pkg;

  // ------------------------------
  // sizing defaults
  // ------------------------------

  // channels served by the steering block
  localparam int NUM_CH_DEF      = 4;
  // master interfaces actually fitted
  localparam int NUM_MASTERS_DEF = 2;
  // codes the select field can express
  localparam int MAX_MASTERS     = 4;
  // read data width, one width for every master
  localparam int DATA_W          = 32;

  // select field width follows the number of codes
  localparam int MS_W = $clog2(MAX_MASTERS);

  // ------------------------------
  // master select code
  // ------------------------------

  // ctlx.sms / ctlx.dms / llpx.lms encoding
  typedef enum logic [MS_W-1:0] {
    MS_M1 = 2'd0,
    MS_M2 = 2'd1,
    MS_M3 = 2'd2,
    MS_M4 = 2'd3
  } master_sel_e;

endpackage

`default_nettype wire
